//--- tx_engine.f
+incdir+include
src/pcie_tlp_pkg.sv
src/axis_beat_pkg.sv
src/cpl_byte_decode.sv
src/cpl_tx.sv
src/rq_tx.sv
src/tx_engine.sv
sim/tb_tx_engine.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tx_engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tx_engine.f --top-module tb_tx_engine \
   -o tb_tx_engine > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/tb_tx_engine > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
   echo "no pass line in sim.log"
   exit 1
fi
exit 0

//--- sim/tb_tx_engine.sv
`timescale 1ns/100ps
`include "tx_engine_cfg.svh"

module tb_tx_engine;

   // cycle budgets per test, watchdog limit is their sum
   localparam int IDLE_CYC = 20;
   localparam int CPL_CYC  = 12 * 30;
   localparam int MWR_CYC  = 4 * 300;
   localparam int RAND_CYC = 4 * 1200;
   localparam int IRST_CYC = 400;
   localparam int BUDGET   = 40 + IDLE_CYC + CPL_CYC + MWR_CYC + RAND_CYC + IRST_CYC;

   logic clk;
   logic rst_n, init_rst_i;
   logic req_compl_i, s_axis_cc_tready_i;
   logic [2:0] req_tc_i;
   logic [1:0] req_attr_i;
   logic [9:0] req_len_i;
   logic [15:0] req_rid_i;
   logic [7:0] req_tag_i, req_be_i;
   logic [10:0] req_addr_i;
   logic [31:0] rd_data_i;
   logic compl_done_o, s_axis_cc_tlast_o, s_axis_cc_tvalid_o;
   logic [8:0] rd_addr_o;
   logic [3:0] rd_be_o;
   axis_beat_pkg::data_t s_axis_cc_tdata_o, s_axis_rq_tdata_o, fifo_data_i;
   axis_beat_pkg::keep_t s_axis_cc_tkeep_o, s_axis_rq_tkeep_o;
   axis_beat_pkg::cc_tuser_t s_axis_cc_tuser_o;
   axis_beat_pkg::rq_tuser_t s_axis_rq_tuser_o;
   logic mwr_start_i, mwr_done_o, fifo_empty_i, fifo_rd_en_o;
   logic [9:0] mwr_len_i;
   logic [31:0] mwr_addr_i;
   logic [3:0] mwr_fbe_i, mwr_lbe_i;
   logic s_axis_rq_tready_i, s_axis_rq_tlast_o, s_axis_rq_tvalid_o;

   // show-ahead fifo model
   logic [255:0] fifo_mem [0:4095];
   logic [255:0] exp_q [$];             // expected payload, fifo order
   int rd_ptr, wr_ptr;
   logic gap_q;                         // forced empty cycle
   int seed = 32424;
   int err_count, tests_run, tests_bad;
   bit rand_mode;
   logic [7:0] tag_exp;

   // one byte-enable pattern per completion class
   logic [3:0] be_list [11] = '{4'b1001, 4'b0101, 4'b1010, 4'b0011, 4'b0110, 4'b1100,
                                4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0000};

   assign fifo_data_i  = fifo_mem[rd_ptr];
   assign fifo_empty_i = (rd_ptr == wr_ptr) || gap_q;

   tx_engine u_tx_engine (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // pop on rd_en, random back-pressure and empty gaps in test 5
   always @(posedge clk) begin
      if (fifo_rd_en_o) rd_ptr <= rd_ptr + 1;
      if (rand_mode) begin
         s_axis_rq_tready_i <= (($random(seed) % 4) != 0);
         gap_q              <= (($random(seed) % 4) == 0);
      end
   end

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   task automatic compare_value(input string name, input logic [255:0] exp, act);
      if (exp !== act) begin
         err_count++;
         $display("error %s: expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      if (err_count == errs_before) begin
         $display("%s: ok", name);
      end else begin
         tests_bad++;
         $display("%s: bad, %0d errors", name, err_count - errs_before);
      end
   endtask

   task automatic fill_fifo(input int words);
      logic [255:0] w;
      for (int i = 0; i < words; i++) begin
         for (int d = 0; d < 8; d++) w[d*32 +: 32] = $random(seed);
         fifo_mem[wr_ptr] = w;
         wr_ptr++;
         exp_q.push_back(w);
      end
   endtask

   // byte count table of the completer
   function automatic logic [12:0] bytes_from_be(input logic [3:0] be);
      if (be[3] && be[0]) return 13'd4;
      if ((be[3:2] == 2'b01 && be[0]) || (be[3] && be[1:0] == 2'b10)) return 13'd3;
      if (be == 4'b0011 || be == 4'b0110 || be == 4'b1100) return 13'd2;
      return 13'd1;
   endfunction

   // lowest enabled byte position
   function automatic logic [1:0] low_bits_from_be(input logic [3:0] be);
      if (be == 4'b0000 || be[0]) return 2'd0;
      if (be[1]) return 2'd1;
      if (be[2]) return 2'd2;
      return 2'd3;
   endfunction

   // ------------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------------
   task automatic idle_test;
      int errs;
      errs = err_count;
      repeat (IDLE_CYC) begin
         @(posedge clk);
         compare_value("idle cc_tvalid", 256'(0), 256'(s_axis_cc_tvalid_o));
         compare_value("idle rq_tvalid", 256'(0), 256'(s_axis_rq_tvalid_o));
         compare_value("idle compl_done", 256'(0), 256'(compl_done_o));
         compare_value("idle mwr_done", 256'(0), 256'(mwr_done_o));
         compare_value("idle fifo_rd_en", 256'(0), 256'(fifo_rd_en_o));
      end
      finish_test("idle after reset", errs);
   endtask

   task automatic cpl_test(input string name, input logic [3:0] be, input int stall);
      logic [255:0] e;
      logic [10:0] addr;
      int errs, done_cnt, xfers, held;
      bit seen;
      errs = err_count;
      addr = 11'($random(seed));
      e = '0;
      e[127:96] = $random(seed);
      e[6:0]    = {addr[4:0], low_bits_from_be(be)};
      e[28:16]  = bytes_from_be(be);
      e[42:32]  = 11'd1;
      e[63:48]  = 16'($random(seed));
      e[71:64]  = 8'($random(seed));
      e[91:89]  = 3'($random(seed));
      e[93:92]  = 2'($random(seed));   // attr msb stays 0
      req_be_i <= {4'h0, be};
      req_addr_i <= addr;
      req_len_i <= 10'd1;
      req_rid_i <= e[63:48];
      req_tag_i <= e[71:64];
      req_tc_i <= e[91:89];
      req_attr_i <= e[93:92];
      rd_data_i <= e[127:96];
      req_compl_i <= 1'b1;
      s_axis_cc_tready_i <= (stall == 0);
      seen = 0;
      done_cnt = 0;
      xfers = 0;
      held = 0;
      for (int cyc = 0; cyc < stall + 12; cyc++) begin
         @(posedge clk);
         if (compl_done_o) done_cnt++;
         if (s_axis_cc_tvalid_o) begin
            if (!seen) begin
               seen = 1;
               compare_value({name, " done with tvalid"}, 256'(1), 256'(compl_done_o));
               compare_value({name, " rd_addr"}, 256'(addr[10:2]), 256'(rd_addr_o));
               compare_value({name, " rd_be"}, 256'(be), 256'(rd_be_o));
               req_compl_i <= 1'b0;     // request released
               // inputs are free after done, the beat must not follow them
               rd_data_i <= ~e[127:96];
               req_rid_i <= ~e[63:48];
               req_addr_i <= ~addr;
            end
            compare_value({name, " tdata"}, e, s_axis_cc_tdata_o);
            compare_value({name, " tkeep"}, 256'(8'h0F), 256'(s_axis_cc_tkeep_o));
            compare_value({name, " tlast"}, 256'(1), 256'(s_axis_cc_tlast_o));
            compare_value({name, " tuser"}, 256'(0), 256'(s_axis_cc_tuser_o));
            if (s_axis_cc_tready_i) xfers++;
         end
         if (seen) begin
            if (held == stall) s_axis_cc_tready_i <= 1'b1;
            held++;
         end
      end
      if (!seen) begin
         err_count++;
         $display("%s: the completion beat never became valid", name);
      end
      compare_value({name, " transfers"}, 256'(1), 256'(xfers));
      compare_value({name, " done pulses"}, 256'(1), 256'(done_cnt));
      s_axis_cc_tready_i <= 1'b1;
      finish_test(name, errs);
   endtask

   task automatic mwr_test(input string name, input int len, input logic [31:0] addr,
                           input logic [3:0] fbe, lbe);
      logic [255:0] hdr, pay;
      logic [7:0] keep;
      int errs, nbeats, beat, done_cnt, cyc, limit;
      errs = err_count;
      nbeats = (len + 7) / 8;
      limit = 40 + 16 * nbeats;
      fill_fifo(nbeats);
      hdr = '0;
      hdr[31:2]   = addr[31:2];
      hdr[74:64]  = 11'(len);
      hdr[78:75]  = 4'b0001;           // memory write
      hdr[103:96] = tag_exp;
      mwr_len_i <= 10'(len);
      mwr_addr_i <= addr;
      mwr_fbe_i <= fbe;
      mwr_lbe_i <= lbe;
      mwr_start_i <= 1'b1;
      beat = 0;
      done_cnt = 0;
      cyc = 0;
      while (done_cnt == 0 && cyc < limit) begin
         @(posedge clk);
         cyc++;
         if (s_axis_rq_tvalid_o) mwr_start_i <= 1'b0;
         if (mwr_done_o) done_cnt++;
         if (s_axis_rq_tvalid_o && s_axis_rq_tready_i) begin
            if (beat == 0) begin
               compare_value({name, " header"}, hdr, s_axis_rq_tdata_o);
               compare_value({name, " header keep"}, 256'(8'hFF), 256'(s_axis_rq_tkeep_o));
               compare_value({name, " header tlast"}, 256'(0), 256'(s_axis_rq_tlast_o));
               compare_value({name, " tuser"}, 256'({(len == 1) ? 4'h0 : lbe, fbe}),
                             256'(s_axis_rq_tuser_o));
            end else begin
               pay = (exp_q.size() > 0) ? exp_q.pop_front() : 'x;
               keep = 8'hFF;
               if (beat == nbeats && (len % 8) != 0) keep = 8'((1 << (len % 8)) - 1);
               compare_value({name, " payload"}, pay, s_axis_rq_tdata_o);
               compare_value({name, " keep"}, 256'(keep), 256'(s_axis_rq_tkeep_o));
               compare_value({name, " tlast"}, 256'(beat == nbeats), 256'(s_axis_rq_tlast_o));
            end
            beat++;
         end
      end
      mwr_start_i <= 1'b0;
      if (done_cnt == 0) begin
         err_count++;
         $display("%s: mwr_done did not pulse within %0d cycles", name, limit);
      end
      repeat (3) begin
         @(posedge clk);
         if (mwr_done_o) done_cnt++;
      end
      compare_value({name, " beats"}, 256'(nbeats + 1), 256'(beat));
      compare_value({name, " done pulses"}, 256'(1), 256'(done_cnt));
      compare_value({name, " fifo words left"}, 256'(wr_ptr), 256'(rd_ptr));
      tag_exp++;
      finish_test(name, errs);
   endtask

   task automatic init_rst_test;
      int errs, xfers, cyc;
      errs = err_count;
      fill_fifo(5);
      mwr_len_i <= 10'd40;
      mwr_addr_i <= 32'h0000_2000;
      mwr_start_i <= 1'b1;
      xfers = 0;
      cyc = 0;
      while (xfers < 2 && cyc < 50) begin
         @(posedge clk);
         cyc++;
         if (s_axis_rq_tvalid_o) mwr_start_i <= 1'b0;
         if (s_axis_rq_tvalid_o && s_axis_rq_tready_i) xfers++;
      end
      mwr_start_i <= 1'b0;
      if (xfers < 2) begin
         err_count++;
         $display("init_rst mid packet: header and first payload beat never transferred");
      end
      init_rst_i <= 1'b1;              // three payload beats still to load
      @(posedge clk);
      init_rst_i <= 1'b0;
      @(posedge clk);
      compare_value("init_rst rq_tvalid", 256'(0), 256'(s_axis_rq_tvalid_o));
      compare_value("init_rst fifo_rd_en", 256'(0), 256'(fifo_rd_en_o));
      rd_ptr <= wr_ptr;                // drop the rest of the aborted packet
      exp_q.delete();
      tag_exp = 8'd0;
      @(posedge clk);
      finish_test("init_rst mid packet", errs);
   endtask

   initial begin
      #(BUDGET * 4);
      $display("timeout: the tests did not finish within %0d cycles", BUDGET);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      rst_n <= 1'b0;
      init_rst_i <= 1'b0;
      req_compl_i <= 1'b0;
      req_tc_i <= '0;
      req_attr_i <= '0;
      req_len_i <= '0;
      req_rid_i <= '0;
      req_tag_i <= '0;
      req_be_i <= '0;
      req_addr_i <= '0;
      rd_data_i <= '0;
      s_axis_cc_tready_i <= 1'b1;
      mwr_start_i <= 1'b0;
      mwr_len_i <= '0;
      mwr_addr_i <= '0;
      mwr_fbe_i <= '0;
      mwr_lbe_i <= '0;
      s_axis_rq_tready_i <= 1'b1;
      gap_q <= 1'b0;
      rd_ptr <= 0;
      wr_ptr = 0;
      tag_exp = 8'd0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      idle_test();
      foreach (be_list[i]) cpl_test($sformatf("cpl be %b", be_list[i]), be_list[i], 0);
      cpl_test("cpl back-pressure", 4'b1111, 6);
      mwr_test("mwr len 1", 1, 32'h0000_1004, 4'hF, 4'hF);
      mwr_test("mwr len 8", 8, 32'h0001_0000, 4'hE, 4'h7);
      mwr_test("mwr len 13", 13, 32'hFFFF_FFC0, 4'hF, 4'h3);
      mwr_test("mwr len 1016", 1016, 32'h8000_0100, 4'hC, 4'hF);
      rand_mode = 1;
      mwr_test("rand len 1", 1, 32'h0000_1004, 4'hF, 4'hF);
      mwr_test("rand len 8", 8, 32'h0001_0000, 4'hE, 4'h7);
      mwr_test("rand len 13", 13, 32'hFFFF_FFC0, 4'hF, 4'h3);
      mwr_test("rand len 1016", 1016, 32'h8000_0100, 4'hC, 4'hF);
      rand_mode = 0;
      gap_q <= 1'b0;
      s_axis_rq_tready_i <= 1'b1;
      @(posedge clk);
      init_rst_test();
      mwr_test("mwr after init_rst", 13, 32'h0000_0040, 4'hF, 4'hF);
      $display("tests run %0d, failing %0d, errors %0d", tests_run, tests_bad, err_count);
      if (err_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- src/tx_engine.sv
`timescale 1ns/100ps
`include "tx_engine_cfg.svh"

module tx_engine (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          init_rst_i,
   // completer completion
   input  logic                          req_compl_i,
   input  logic [2:0]                    req_tc_i,
   input  logic [1:0]                    req_attr_i,
   input  logic [`TX_LEN_W-1:0]          req_len_i,
   input  logic [15:0]                   req_rid_i,
   input  logic [`TX_TAG_W-1:0]          req_tag_i,
   input  logic [7:0]                    req_be_i,
   input  logic [`TX_REQ_ADDR_W-1:0]     req_addr_i,
   input  axis_beat_pkg::dw_t            rd_data_i,
   output logic                          compl_done_o,
   output logic [`TX_REQ_ADDR_W-3:0]     rd_addr_o,
   output logic [3:0]                    rd_be_o,
   input  logic                          s_axis_cc_tready_i,
   output axis_beat_pkg::data_t          s_axis_cc_tdata_o,
   output axis_beat_pkg::keep_t          s_axis_cc_tkeep_o,
   output axis_beat_pkg::cc_tuser_t      s_axis_cc_tuser_o,
   output logic                          s_axis_cc_tlast_o,
   output logic                          s_axis_cc_tvalid_o,
   // requester memory write
   input  logic                          mwr_start_i,
   input  logic [`TX_LEN_W-1:0]          mwr_len_i,
   input  logic [`TX_ADDR_W-1:0]         mwr_addr_i,
   input  logic [3:0]                    mwr_fbe_i,
   input  logic [3:0]                    mwr_lbe_i,
   output logic                          mwr_done_o,
   input  axis_beat_pkg::data_t          fifo_data_i,
   input  logic                          fifo_empty_i,
   output logic                          fifo_rd_en_o,
   input  logic                          s_axis_rq_tready_i,
   output axis_beat_pkg::data_t          s_axis_rq_tdata_o,
   output axis_beat_pkg::keep_t          s_axis_rq_tkeep_o,
   output axis_beat_pkg::rq_tuser_t      s_axis_rq_tuser_o,
   output logic                          s_axis_rq_tlast_o,
   output logic                          s_axis_rq_tvalid_o
);

   // ------------------------------------------------------------------------
   // completion path, one dword read completions
   // ------------------------------------------------------------------------
   cpl_tx u_cpl_tx (
      .clk          (clk),
      .rst_n        (rst_n),
      .init_rst_i   (init_rst_i),
      .req_compl_i  (req_compl_i),
      .req_tc_i     (req_tc_i),
      .req_attr_i   (req_attr_i),
      .req_len_i    (req_len_i),
      .req_rid_i    (req_rid_i),
      .req_tag_i    (req_tag_i),
      .req_be_i     (req_be_i),
      .req_addr_i   (req_addr_i),
      .rd_data_i    (rd_data_i),
      .cc_tready_i  (s_axis_cc_tready_i),
      .cc_tdata_o   (s_axis_cc_tdata_o),
      .cc_tkeep_o   (s_axis_cc_tkeep_o),
      .cc_tuser_o   (s_axis_cc_tuser_o),
      .cc_tlast_o   (s_axis_cc_tlast_o),
      .cc_tvalid_o  (s_axis_cc_tvalid_o),
      .compl_done_o (compl_done_o),
      .rd_addr_o    (rd_addr_o),
      .rd_be_o      (rd_be_o)
   );

   // ------------------------------------------------------------------------
   // request path, memory writes fed from the tx fifo
   // ------------------------------------------------------------------------
   rq_tx u_rq_tx (
      .clk          (clk),
      .rst_n        (rst_n),
      .init_rst_i   (init_rst_i),
      .mwr_start_i  (mwr_start_i),
      .mwr_len_i    (mwr_len_i),
      .mwr_addr_i   (mwr_addr_i),
      .mwr_fbe_i    (mwr_fbe_i),
      .mwr_lbe_i    (mwr_lbe_i),
      .fifo_data_i  (fifo_data_i),
      .fifo_empty_i (fifo_empty_i),
      .fifo_rd_en_o (fifo_rd_en_o),
      .rq_tready_i  (s_axis_rq_tready_i),
      .rq_tdata_o   (s_axis_rq_tdata_o),
      .rq_tkeep_o   (s_axis_rq_tkeep_o),
      .rq_tuser_o   (s_axis_rq_tuser_o),
      .rq_tlast_o   (s_axis_rq_tlast_o),
      .rq_tvalid_o  (s_axis_rq_tvalid_o),
      .mwr_done_o   (mwr_done_o)
   );

endmodule

//--- src/rq_tx.sv
`timescale 1ns/100ps
`include "tx_engine_cfg.svh"

module rq_tx (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      init_rst_i,
   input  logic                      mwr_start_i,
   input  logic [`TX_LEN_W-1:0]      mwr_len_i,
   input  logic [`TX_ADDR_W-1:0]     mwr_addr_i,
   input  logic [3:0]                mwr_fbe_i,
   input  logic [3:0]                mwr_lbe_i,
   input  axis_beat_pkg::data_t      fifo_data_i,
   input  logic                      fifo_empty_i,
   output logic                      fifo_rd_en_o,
   input  logic                      rq_tready_i,
   output axis_beat_pkg::data_t      rq_tdata_o,
   output axis_beat_pkg::keep_t      rq_tkeep_o,
   output axis_beat_pkg::rq_tuser_t  rq_tuser_o,
   output logic                      rq_tlast_o,
   output logic                      rq_tvalid_o,
   output logic                      mwr_done_o
);

   localparam int BEAT_SH = $clog2(`TX_DW_PER_BEAT);
   localparam logic [`TX_LEN_W-1:0] BEAT_DW = `TX_DW_PER_BEAT;

   // idle: header goes out on start, payload: one fifo word per beat,
   // tail: last beat loaded, wait for it to leave
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PAYLOAD,
      ST_TAIL
   } rq_state_t;

   rq_state_t              state;
   logic [`TX_LEN_W-1:0]   rem_dw;      // dwords not yet loaded
   logic [`TX_LEN_W-1:0]   len_q;       // length of the current packet
   logic [`TX_TAG_W-1:0]   wr_tag;      // running write counter
   logic                   slot_free;
   logic                   load_hdr;
   logic                   load_pay;
   logic                   last_beat;
   axis_beat_pkg::keep_t   keep_mask;
   axis_beat_pkg::keep_t   last_keep;
   pcie_tlp_pkg::rq_desc_t hdr;

   // ------------------------------------------------------------------------
   // load conditions
   // ------------------------------------------------------------------------
   assign slot_free    = !rq_tvalid_o || rq_tready_i;
   assign load_hdr     = (state == ST_IDLE) && mwr_start_i && slot_free;
   assign load_pay     = (state == ST_PAYLOAD) && slot_free && !fifo_empty_i;
   assign fifo_rd_en_o = load_pay;      // show-ahead, pop as the word is taken
   assign last_beat    = (rem_dw <= BEAT_DW);

   // keep of the final beat, low len mod 8 dwords
   always_comb begin
      keep_mask = {`TX_KEEP_W{1'b1}} << len_q[BEAT_SH-1:0];
      if (len_q[BEAT_SH-1:0] == '0) begin
         last_keep = '1;                // full beat
      end else begin
         last_keep = ~keep_mask;
      end
   end

   // memory write header
   always_comb begin
      hdr          = '0;
      hdr.dw_cnt   = 11'(mwr_len_i);
      hdr.req_type = pcie_tlp_pkg::MEM_WR;
      hdr.dw_addr  = 62'(mwr_addr_i[`TX_ADDR_W-1:2]);
      hdr.tag      = wr_tag;
   end

   // ------------------------------------------------------------------------
   // sequencer
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n || init_rst_i) begin
         state       <= ST_IDLE;
         rem_dw      <= '0;
         wr_tag      <= '0;
         rq_tvalid_o <= 1'b0;
         mwr_done_o  <= 1'b0;
      end else begin
         mwr_done_o <= 1'b0;
         if (slot_free) begin
            rq_tvalid_o <= 1'b0;        // slot drains unless reloaded below
         end
         case (state)
            ST_IDLE: begin
               if (load_hdr) begin
                  rq_tvalid_o <= 1'b1;
                  rem_dw      <= mwr_len_i;
                  wr_tag      <= wr_tag + 1'b1;   // wraps at 8 bits
                  state       <= ST_PAYLOAD;
               end
            end
            ST_PAYLOAD: begin
               if (load_pay) begin
                  rq_tvalid_o <= 1'b1;
                  rem_dw      <= rem_dw - BEAT_DW;
                  if (last_beat) begin
                     state <= ST_TAIL;
                  end
               end
            end
            default: begin
               if (rq_tvalid_o && rq_tready_i) begin
                  mwr_done_o <= 1'b1;   // last beat gone
                  state      <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // beat registers, written only when the slot is loaded
   always_ff @(posedge clk) begin
      if (load_hdr) begin
         rq_tdata_o          <= axis_beat_pkg::data_t'(hdr);
         rq_tkeep_o          <= '1;
         rq_tlast_o          <= 1'b0;
         rq_tuser_o.rsvd     <= '0;
         rq_tuser_o.first_be <= mwr_fbe_i;
         rq_tuser_o.last_be  <= (mwr_len_i == 'd1) ? 4'b0000 : mwr_lbe_i;
         len_q               <= mwr_len_i;
      end else if (load_pay) begin
         rq_tdata_o <= fifo_data_i;
         rq_tkeep_o <= last_beat ? last_keep : '1;
         rq_tlast_o <= last_beat;
      end
   end

endmodule

//--- src/cpl_tx.sv
`timescale 1ns/100ps
`include "tx_engine_cfg.svh"

module cpl_tx (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          init_rst_i,
   input  logic                          req_compl_i,
   input  logic [2:0]                    req_tc_i,
   input  logic [1:0]                    req_attr_i,
   input  logic [`TX_LEN_W-1:0]          req_len_i,
   input  logic [15:0]                   req_rid_i,
   input  logic [`TX_TAG_W-1:0]          req_tag_i,
   input  logic [7:0]                    req_be_i,
   input  logic [`TX_REQ_ADDR_W-1:0]     req_addr_i,
   input  axis_beat_pkg::dw_t            rd_data_i,
   input  logic                          cc_tready_i,
   output axis_beat_pkg::data_t          cc_tdata_o,
   output axis_beat_pkg::keep_t          cc_tkeep_o,
   output axis_beat_pkg::cc_tuser_t      cc_tuser_o,
   output logic                          cc_tlast_o,
   output logic                          cc_tvalid_o,
   output logic                          compl_done_o,
   output logic [`TX_REQ_ADDR_W-3:0]     rd_addr_o,
   output logic [3:0]                    rd_be_o
);

   logic                   req_compl_q;  // request, one stage
   logic                   req_taken;    // answered, wait for request to drop
   logic                   load_cpl;
   logic [12:0]            byte_cnt;
   logic [6:0]             lower_addr;
   pcie_tlp_pkg::cc_desc_t cpl_desc;

   // memory read port, dword address
   assign rd_addr_o  = req_addr_i[`TX_REQ_ADDR_W-1:2];
   assign rd_be_o    = req_be_i[3:0];
   assign cc_tuser_o = '0;               // no parity or discontinue

   cpl_byte_decode u_byte_decode (
      .be_i         (rd_be_o),
      .addr_i       (req_addr_i[4:0]),
      .byte_cnt_o   (byte_cnt),
      .lower_addr_o (lower_addr)
   );

   // ------------------------------------------------------------------------
   // descriptor, unused fields stay zero
   // ------------------------------------------------------------------------
   always_comb begin
      cpl_desc            = '0;
      cpl_desc.lower_addr = lower_addr;
      cpl_desc.byte_cnt   = byte_cnt;
      cpl_desc.dw_cnt     = 11'(req_len_i);
      cpl_desc.status     = pcie_tlp_pkg::SUCCESS;
      cpl_desc.req_id     = req_rid_i;
      cpl_desc.tag        = req_tag_i;
      cpl_desc.tc         = req_tc_i;
      cpl_desc.attr       = {1'b0, req_attr_i};
   end

   // slot empty, fresh request pending
   assign load_cpl = !cc_tvalid_o && req_compl_q && !req_taken;

   always_ff @(posedge clk) begin
      if (!rst_n || init_rst_i) begin
         req_compl_q  <= 1'b0;
         req_taken    <= 1'b0;
         cc_tvalid_o  <= 1'b0;
         compl_done_o <= 1'b0;
      end else begin
         req_compl_q  <= req_compl_i;
         compl_done_o <= load_cpl;       // rises with tvalid
         if (load_cpl) begin
            cc_tvalid_o <= 1'b1;
         end else if (cc_tready_i) begin
            cc_tvalid_o <= 1'b0;         // beat accepted
         end
         if (load_cpl) begin
            req_taken <= 1'b1;
         end else if (!req_compl_q) begin
            req_taken <= 1'b0;           // requester released the request
         end
      end
   end

   // beat payload, held while tvalid is high
   always_ff @(posedge clk) begin
      if (load_cpl) begin
         cc_tdata_o <= axis_beat_pkg::data_t'({rd_data_i, cpl_desc});
         cc_tkeep_o <= axis_beat_pkg::keep_t'(4'hF);  // 3 dw header + 1 dw data
         cc_tlast_o <= 1'b1;
      end
   end

endmodule

//--- src/cpl_byte_decode.sv
`timescale 1ns/100ps

module cpl_byte_decode (
   input  logic [3:0]  be_i,
   input  logic [4:0]  addr_i,
   output logic [12:0] byte_cnt_o,
   output logic [6:0]  lower_addr_o
);

   // ------------------------------------------------------------------------
   // byte count from first dword enables
   // ------------------------------------------------------------------------
   always_comb begin
      casez (be_i)
         4'b1??1: byte_cnt_o = 13'd4;   // both end bytes enabled
         4'b01?1: byte_cnt_o = 13'd3;
         4'b1?10: byte_cnt_o = 13'd3;
         4'b0011: byte_cnt_o = 13'd2;
         4'b0110: byte_cnt_o = 13'd2;
         4'b1100: byte_cnt_o = 13'd2;
         default: byte_cnt_o = 13'd1;   // single byte, also be = 0000
      endcase
   end

   // ------------------------------------------------------------------------
   // lower address, low two bits from first enabled byte
   // ------------------------------------------------------------------------
   always_comb begin
      casez (be_i)
         4'b0000: lower_addr_o = {addr_i, 2'b00};  // zero length read
         4'b???1: lower_addr_o = {addr_i, 2'b00};
         4'b??10: lower_addr_o = {addr_i, 2'b01};
         4'b?100: lower_addr_o = {addr_i, 2'b10};
         default: lower_addr_o = {addr_i, 2'b11};  // only byte 3
      endcase
   end

endmodule

//--- src/axis_beat_pkg.sv
`include "tx_engine_cfg.svh"

package axis_beat_pkg;

   typedef logic [`TX_DATA_W-1:0]     data_t;
   typedef logic [`TX_KEEP_W-1:0]     keep_t;   // dword granular
   typedef logic [31:0]               dw_t;
   typedef logic [`TX_CC_TUSER_W-1:0] cc_tuser_t;

   // rq sideband, only the byte enables are used
   typedef struct packed {
      logic [`TX_RQ_TUSER_W-9:0] rsvd;    // parity, discontinue etc, all zero
      logic [3:0]                last_be;
      logic [3:0]                first_be;
   } rq_tuser_t;

endpackage

//--- src/pcie_tlp_pkg.sv
`include "tx_engine_cfg.svh"

package pcie_tlp_pkg;

   // request type code in the rq descriptor
   typedef enum logic [3:0] {
      MEM_WR = 4'b0001
   } req_type_t;

   typedef enum logic [2:0] {
      SUCCESS = 3'b000          // successful completion
   } cpl_status_t;

   // ------------------------------------------------------------------------
   // 3-DW completion descriptor, msb first
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic                 force_ecrc;
      logic [2:0]           attr;
      logic [2:0]           tc;
      logic                 cpl_id_en;   // 0: core supplies completer id
      logic [15:0]          cpl_id;
      logic [`TX_TAG_W-1:0] tag;
      logic [15:0]          req_id;
      logic                 rsvd3;
      logic                 poisoned;
      cpl_status_t          status;
      logic [10:0]          dw_cnt;
      logic [1:0]           rsvd2;
      logic                 locked;
      logic [12:0]          byte_cnt;
      logic [5:0]           rsvd1;
      logic [1:0]           addr_type;
      logic                 rsvd0;
      logic [6:0]           lower_addr;  // bits 6:0 of the beat
   } cc_desc_t;

   // ------------------------------------------------------------------------
   // 4-DW request descriptor, msb first
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic                 force_ecrc;
      logic [2:0]           attr;
      logic [2:0]           tc;
      logic                 req_id_en;
      logic [15:0]          cpl_id;
      logic [`TX_TAG_W-1:0] tag;
      logic [15:0]          req_id;
      logic                 poisoned;
      req_type_t            req_type;
      logic [10:0]          dw_cnt;
      logic [61:0]          dw_addr;     // address bits 63:2
      logic [1:0]           addr_type;
   } rq_desc_t;

endpackage

//--- include/tx_engine_cfg.svh
`ifndef TX_ENGINE_CFG_SVH
`define TX_ENGINE_CFG_SVH

// ---------------------------------------------------------------------------
// stream geometry
// ---------------------------------------------------------------------------
`define TX_DATA_W       256   // beat data
`define TX_KEEP_W       8     // one keep bit per dword
`define TX_DW_PER_BEAT  8

// ---------------------------------------------------------------------------
// request fields
// ---------------------------------------------------------------------------
`define TX_LEN_W        10    // dword count, max 1023
`define TX_TAG_W        8
`define TX_ADDR_W       32    // mwr byte address
`define TX_REQ_ADDR_W   11    // completer side request address

// sideband words of the two streams
`define TX_CC_TUSER_W   33
`define TX_RQ_TUSER_W   60

`endif
